//--- mdc_pkg.sv
// Matrix minor calculator types
`default_nettype none

package mdc_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    // Hamming(15,11) codeword
    localparam int CODE_W  = 15;
    // Signed matrix element after correction
    localparam int ELEM_W  = 11;
    // Full product of two elements
    localparam int PROD_W  = 2 * ELEM_W;
    // One bit of headroom for the difference of two products
    localparam int MINOR_W = PROD_W + 1;
    // Slot index into the packed output word
    localparam int SLOT_W  = 8;

    // ======================================================================
    // Scalar types
    // ======================================================================
    typedef logic        [CODE_W-1:0]  code_t;
    typedef logic signed [ELEM_W-1:0]  elem_t;
    typedef logic signed [PROD_W-1:0]  prod_t;
    typedef logic signed [MINOR_W-1:0] minor_t;
    typedef logic        [SLOT_W-1:0]  slot_t;

    // ======================================================================
    // Lane traffic
    // ======================================================================
    // One 2x2 block, window to lane
    typedef struct packed {
        logic  valid;
        slot_t slot;
        elem_t top_left;
        elem_t top_right;
        elem_t bottom_left;
        elem_t bottom_right;
    } minor_req_t;

    // One finished minor, lane to packer
    typedef struct packed {
        logic   valid;
        slot_t  slot;
        minor_t value;
    } minor_res_t;

endpackage

`default_nettype wire

//--- hamming_15_11_dec.sv
// Hamming 15/11 decoder
`default_nettype none

module hamming_15_11_dec import mdc_pkg::*; (
    input  code_t code,
    output elem_t data
);

    // Syndrome holds a position from 1 to 15, zero when clean
    localparam int SYN_W = 4;

    logic [SYN_W-1:0] syndrome;
    code_t            fixed;

    // Position p sits at bit CODE_W-p, so position 1 is the MSB
    always_comb begin
        syndrome = '0;
        for (int p = 1; p <= CODE_W; p++) begin
            if (code[CODE_W-p]) begin
                syndrome = syndrome ^ SYN_W'(p);
            end
        end
    end

    // Flip the single bit the syndrome points at
    always_comb begin
        for (int p = 1; p <= CODE_W; p++) begin
            fixed[CODE_W-p] = code[CODE_W-p] ^ (syndrome == SYN_W'(p));
        end
    end

    // ======================================================================
    // Data extraction
    // ======================================================================
    // Parity at positions 1, 2, 4, 8 (bits 14, 13, 11, 7)
    //   pos 3       -> bit 12 -> data[10]
    //   pos 5..7    -> bits 10..8 -> data[9:7]
    //   pos 9..15   -> bits 6..0 -> data[6:0]
    assign data = elem_t'({fixed[12], fixed[10:8], fixed[6:0]});

endmodule

`default_nettype wire

//--- matrix_window.sv
// Matrix sample window
`default_nettype none

module matrix_window import mdc_pkg::*; #(
    parameter int MAT_N = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  elem_t                    elem,
    output minor_req_t [MAT_N-2:0]   req
);

    localparam int NUM_LANES = MAT_N - 1;
    localparam int IDX_W     = $clog2(MAT_N);

    // Position of the sample now on elem
    logic [IDX_W-1:0] row_idx;
    logic [IDX_W-1:0] col_idx;

    // hist[0] is the previous sample, hist[MAT_N] is MAT_N+1 samples back
    elem_t hist [MAT_N+1];

    logic [IDX_W-1:0]     blk_row;
    logic [IDX_W-1:0]     blk_col;
    slot_t                blk_slot;
    logic                 issue;
    logic [NUM_LANES-1:0] req_valid_vec;

    // ======================================================================
    // Sample counter
    // ======================================================================
    // Any idle cycle restarts the matrix
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_idx <= '0;
            col_idx <= '0;
        end else if (!in_valid) begin
            row_idx <= '0;
            col_idx <= '0;
        end else if (col_idx == IDX_W'(MAT_N - 1)) begin
            col_idx <= '0;
            row_idx <= (row_idx == IDX_W'(MAT_N - 1)) ? '0 : row_idx + 1'b1;
        end else begin
            col_idx <= col_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            hist[0] <= elem;
            for (int i = MAT_N; i > 0; i--) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    // ======================================================================
    // Block requests
    // ======================================================================
    // Current sample closes the block whose top-left is one row up, one left
    assign issue    = in_valid && (row_idx != '0) && (col_idx != '0);
    assign blk_row  = row_idx - 1'b1;
    assign blk_col  = col_idx - 1'b1;
    assign blk_slot = slot_t'(blk_row * (MAT_N - 1) + blk_col);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req <= '0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                req[l].valid <= 1'b0;
            end
            if (issue) begin
                req[blk_col] <= '{valid:        1'b1,
                                  slot:         blk_slot,
                                  top_left:     hist[MAT_N],
                                  top_right:    hist[MAT_N-1],
                                  bottom_left:  hist[0],
                                  bottom_right: elem};
            end
        end
    end

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            req_valid_vec[l] = req[l].valid;
        end
    end

    // Requests only follow an accepted sample, and only one lane at a time
    a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
        |req_valid_vec |-> $onehot(req_valid_vec) && $past(in_valid))
        else $error("lane request without a sample or on several lanes");

endmodule

`default_nettype wire

//--- minor_lane.sv
// 2x2 determinant lane
`default_nettype none

module minor_lane import mdc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  minor_req_t req,
    output minor_res_t res
);

    // Stage one, cross products
    logic  s1_valid;
    slot_t s1_slot;
    prod_t s1_prod_main;
    prod_t s1_prod_anti;

    // Stage two, difference
    logic   s2_valid;
    slot_t  s2_slot;
    minor_t s2_value;

    // ======================================================================
    // Valid pipeline
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
            s2_valid <= s1_valid;
        end
    end

    // ======================================================================
    // Datapath
    // ======================================================================
    always_ff @(posedge clk) begin
        if (req.valid) begin
            s1_slot      <= req.slot;
            s1_prod_main <= req.top_left * req.bottom_right;
            s1_prod_anti <= req.top_right * req.bottom_left;
        end
        if (s1_valid) begin
            s2_slot  <= s1_slot;
            // Worst case 2^20 + (2^20 - 2^10) still fits in 23 bits
            s2_value <= minor_t'(s1_prod_main) - minor_t'(s1_prod_anti);
        end
    end

    assign res = '{valid: s2_valid, slot: s2_slot, value: s2_value};

    a_lane_latency: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> ##2 (res.valid && res.slot == $past(req.slot, 2)))
        else $error("lane result missing or slot changed two cycles after request");

endmodule

`default_nettype wire

//--- result_packer.sv
// Minor result packer
`default_nettype none

module result_packer import mdc_pkg::*; #(
    parameter int MAT_N = 4
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  minor_res_t [MAT_N-2:0]                      res,
    output logic                                        out_valid,
    output logic [(MAT_N-1)*(MAT_N-1)*MINOR_W-1:0]      out_data
);

    localparam int NUM_LANES = MAT_N - 1;
    localparam int NUM_SLOTS = NUM_LANES * NUM_LANES;
    localparam int OUT_W     = NUM_SLOTS * MINOR_W;

    minor_t               slot_q [NUM_SLOTS];
    minor_t               wdata  [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] hit;
    logic [NUM_SLOTS-1:0] mask;
    logic [NUM_SLOTS-1:0] mask_next;
    logic [OUT_W-1:0]     word;

    // ======================================================================
    // Slot capture
    // ======================================================================
    // Route each lane result to the slot it names
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            hit[s]   = 1'b0;
            wdata[s] = '0;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (res[l].valid && res[l].slot == slot_t'(s)) begin
                    hit[s]   = 1'b1;
                    wdata[s] = res[l].value;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (hit[s]) begin
                slot_q[s] <= wdata[s];
            end
        end
    end

    assign mask_next = mask | hit;

    // Fire once every slot is filled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask      <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= &mask_next;
            mask      <= (&mask_next) ? '0 : mask_next;
        end
    end

    // ======================================================================
    // Output word
    // ======================================================================
    // Slot 0 at the top bits
    always_comb begin
        word = '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            word[OUT_W-1-s*MINOR_W -: MINOR_W] = slot_q[s];
        end
    end

    assign out_data = out_valid ? word : '0;

    a_no_rewrite: assert property (@(posedge clk) disable iff (!rst_n)
        (hit & mask) == '0)
        else $error("minor slot written twice before the packed word went out");

endmodule

`default_nettype wire

//--- mdc_top.sv
// Matrix minor calculator
`default_nettype none

module mdc_top import mdc_pkg::*; #(
    parameter int MAT_N = 4
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     in_valid,
    input  code_t                                    in_data,
    output logic                                     out_valid,
    output logic [(MAT_N-1)*(MAT_N-1)*MINOR_W-1:0]   out_data
);

    elem_t                 dec_elem;
    minor_req_t [MAT_N-2:0] lane_req;
    minor_res_t [MAT_N-2:0] lane_res;

    // ======================================================================
    // Input side
    // ======================================================================
    hamming_15_11_dec u_dec (
        .code (in_data),
        .data (dec_elem)
    );

    matrix_window #(
        .MAT_N (MAT_N)
    ) u_window (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .elem     (dec_elem),
        .req      (lane_req)
    );

    // ======================================================================
    // One lane per block column
    // ======================================================================
    for (genvar l = 0; l < MAT_N - 1; l++) begin : g_lane
        minor_lane u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (lane_req[l]),
            .res   (lane_res[l])
        );
    end

    // ======================================================================
    // Output side
    // ======================================================================
    result_packer #(
        .MAT_N (MAT_N)
    ) u_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (lane_res),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- tb_mdc_model.svh
// Testbench reference model
`ifndef TB_MDC_MODEL_SVH
`define TB_MDC_MODEL_SVH

// ======================================================================
// Random source
// ======================================================================
// One Galois step, the bit shifted out is the random bit
function automatic logic lfsr_step();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return out_bit;
endfunction

// Gather n random bits, one step each
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], lfsr_step()};
    end
    return value;
endfunction

// ======================================================================
// Hamming encoder
// ======================================================================
// Position 1 is bit 14, data fills the non-power-of-two positions MSB first
function automatic code_t hamming_encode(input elem_t data);
    code_t      cw;
    logic [3:0] syn;
    logic       data_bit;
    int         di;
    cw  = '0;
    syn = '0;
    di  = ELEM_W - 1;
    for (int p = 1; p <= CODE_W; p++) begin
        if ((p & (p - 1)) != 0) begin
            data_bit       = data[di];
            cw[CODE_W - p] = data_bit;
            if (data_bit) begin
                syn = syn ^ 4'(p);
            end
            di = di - 1;
        end
    end
    // Parity bits cancel the syndrome of the data bits
    for (int k = 0; k < 4; k++) begin
        cw[CODE_W - (1 << k)] = syn[k];
    end
    return cw;
endfunction

// ======================================================================
// Reference minors
// ======================================================================
// Block r, c lands in slot r*(MAT_N-1)+c, slot 0 at the top bits
function automatic logic [OUT_W-1:0] ref_word();
    logic [OUT_W-1:0] word;
    int               minor;
    int               slot;
    word = '0;
    for (int r = 0; r < NUM_LANES; r++) begin
        for (int c = 0; c < NUM_LANES; c++) begin
            minor = cur_mat[r*MAT_N + c] * cur_mat[(r+1)*MAT_N + c + 1]
                  - cur_mat[r*MAT_N + c + 1] * cur_mat[(r+1)*MAT_N + c];
            slot  = r * NUM_LANES + c;
            word[OUT_W-1-slot*MINOR_W -: MINOR_W] = minor_t'(minor);
        end
    end
    return word;
endfunction

`endif

//--- tb_mdc.sv
// Matrix minor calculator testbench
`default_nettype none

module tb_mdc
    import mdc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MAT_N          = 4;
    localparam int          NUM_ELEMS      = MAT_N * MAT_N;
    localparam int          NUM_LANES      = MAT_N - 1;
    localparam int          OUT_W          = NUM_LANES * NUM_LANES * MINOR_W;
    localparam int          LATENCY        = 4;
    localparam int          NUM_MATRICES   = 14;
    localparam int          TIMEOUT_CYCLES = NUM_MATRICES * 25 + 100;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             in_valid;
    code_t            in_data;
    logic             out_valid;
    logic [OUT_W-1:0] out_data;

    logic [31:0]      lfsr_state = 32'ha6a8_241d;
    int               cur_mat [NUM_ELEMS];

    // Expected words and the cycle each one is due in
    logic [OUT_W-1:0] exp_word_q [$];
    int               exp_cyc_q  [$];
    logic             head_ok = 1'b0;
    logic [OUT_W-1:0] head_word = '0;
    int               head_cyc = 0;

    int cyc          = 0;
    int err_cnt      = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int results_seen = 0;

    `include "tb_mdc_model.svh"

    always #20 clk = ~clk;

    mdc_top #(
        .MAT_N (MAT_N)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    // ======================================================================
    // Scoreboard queue
    // ======================================================================
    task automatic refresh_head();
        head_ok = (exp_word_q.size() != 0);
        if (head_ok) begin
            head_word = exp_word_q[0];
            head_cyc  = exp_cyc_q[0];
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst_n && out_valid && exp_word_q.size() != 0) begin
            void'(exp_word_q.pop_front());
            void'(exp_cyc_q.pop_front());
            results_seen++;
            refresh_head();
        end
    end

    always @(posedge clk) begin
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_data == '0)
        else begin
            $display("Error [%0t] out_data %h while out_valid is low", $time, $sampled(out_data));
            err_cnt++;
        end

    a_expected: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> head_ok)
        else begin
            $display("Unexpected out_valid at %0t with no matrix pending", $time);
            err_cnt++;
        end

    a_value: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && head_ok |-> out_data == head_word)
        else begin
            $display("Error [%0t] minors %h, expected %h", $time, $sampled(out_data),
                     $sampled(head_word));
            err_cnt++;
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && head_ok |-> cyc == head_cyc)
        else begin
            $display("Error [%0t] out_valid in cycle %0d, expected cycle %0d", $time,
                     $sampled(cyc), $sampled(head_cyc));
            err_cnt++;
        end

    a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin
            $display("out_valid stayed high for more than one cycle at %0t", $time);
            err_cnt++;
        end

    a_not_late: assert property (@(posedge clk) disable iff (!rst_n)
        head_ok |-> cyc <= head_cyc)
        else begin
            $display("Result due in cycle %0d never arrived (at %0t)", $sampled(head_cyc), $time);
            err_cnt++;
        end

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic send_matrix(input bit flip);
        code_t cw;
        int    pos;
        for (int i = 0; i < NUM_ELEMS; i++) begin
            @(negedge clk);
            cw = hamming_encode(elem_t'(cur_mat[i]));
            if (flip) begin
                pos     = int'(take_bits(4)) % CODE_W;
                cw[pos] = ~cw[pos];
            end
            in_valid = 1'b1;
            in_data  = cw;
        end
        exp_word_q.push_back(ref_word());
        exp_cyc_q.push_back(cyc + LATENCY);
        refresh_head();
        @(negedge clk);
        in_valid = 1'b0;
        in_data  = '0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < NUM_ELEMS; i++) begin
            cur_mat[i] = int'(elem_t'(take_bits(ELEM_W)));
        end
    endtask

    // Four sign patterns of the two extreme values
    task automatic fill_extreme(input int mode);
        int r;
        int c;
        for (int i = 0; i < NUM_ELEMS; i++) begin
            r = i / MAT_N;
            c = i % MAT_N;
            case (mode)
                0:       cur_mat[i] = -1024;
                1:       cur_mat[i] = 1023;
                2:       cur_mat[i] = ((r + c) % 2 != 0) ? 1023 : -1024;
                default: cur_mat[i] = (r % 2 == 0 && c % 2 == 1) ? 1023 : -1024;
            endcase
        end
    endtask

    // Drain the pending results, then stop on a falling edge
    task automatic wait_for_results();
        @(negedge clk);
        while (exp_word_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        wait_for_results();
        tests_run++;
        if (err_cnt != err_before) begin
            tests_failed++;
        end
        $display("Test %-13s %s, %0d errors", name,
                 (err_cnt == err_before) ? "ok" : "had errors", err_cnt - err_before);
    endtask

    initial begin
        int err_before;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle output after reset
        err_before = err_cnt;
        repeat (10) @(posedge clk);
        end_test("reset_idle", err_before);

        err_before = err_cnt;
        for (int m = 0; m < 2; m++) begin
            fill_random();
            send_matrix(1'b0);
            wait_for_results();
        end
        end_test("clean_random", err_before);

        err_before = err_cnt;
        for (int m = 0; m < 3; m++) begin
            fill_random();
            send_matrix(1'b1);
            wait_for_results();
        end
        end_test("bit_flips", err_before);

        err_before = err_cnt;
        for (int m = 0; m < 4; m++) begin
            fill_extreme(m);
            send_matrix(1'b0);
            wait_for_results();
        end
        end_test("extremes", err_before);

        // One idle cycle between matrices
        err_before = err_cnt;
        for (int m = 0; m < 5; m++) begin
            fill_random();
            send_matrix(1'b0);
        end
        end_test("back_to_back", err_before);

        repeat (3) @(posedge clk);
        $display("Tests: %0d run, %0d with errors, %0d check errors, %0d results",
                 tests_run, tests_failed, err_cnt, results_seen);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
mdc_pkg.sv
hamming_15_11_dec.sv
matrix_window.sv
minor_lane.sv
result_packer.sv
mdc_top.sv
tb_mdc.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the matrix minor calculator testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mdc \
    -f sources.f \
    -o Vtb_mdc

./obj_dir/Vtb_mdc | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0
